//--- eth_rx_pkg.sv
//////////////////////////////////////////////////////////////////////
// shared types and constants for the 10G Ethernet receive MAC
// XGMII control codes, vector widths and CRC-32 parameters
//////////////////////////////////////////////////////////////////////

package eth_rx_pkg;

    // one XGMII word, eight byte lanes
    typedef logic [63:0] xgmii_data_t;

    // per-lane control flags, also used as the stream byte keep
    typedef logic [7:0] xgmii_ctrl_t;

    // CRC-32 state or remainder
    typedef logic [31:0] crc_t;

    // one statistics counter
    typedef logic [15:0] frame_count_t;

    // XGMII control characters
    localparam logic [7:0] XGMII_START = 8'hFB;
    localparam logic [7:0] XGMII_TERM  = 8'hFD;
    localparam logic [7:0] XGMII_ERROR = 8'hFE;
    localparam logic [7:0] XGMII_IDLE  = 8'h07;

    // all lanes idle
    localparam xgmii_data_t XGMII_IDLE_WORD = {8{XGMII_IDLE}};
    localparam xgmii_ctrl_t XGMII_IDLE_CTRL = 8'hFF;

    // Ethernet FCS, reflected form, bytes processed lsb first
    localparam crc_t CRC_INIT           = 32'hFFFF_FFFF;
    localparam crc_t CRC_POLY_REFLECTED = 32'hEDB8_8320;

endpackage

//--- eth_crc_update.sv
//////////////////////////////////////////////////////////////////////
// CRC-32 next-state logic for the 10G receive MAC
// advances a reflected CRC over a configurable number of data bytes
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ns

module eth_crc_update #(
    // number of data bytes consumed per step, 1 to 8
    parameter int data_bytes = 8
) (
    input  logic [8*data_bytes-1:0] data_in,
    input  eth_rx_pkg::crc_t        crc_state,
    output eth_rx_pkg::crc_t        crc_next
);
    import eth_rx_pkg::*;

    // one serial LFSR step for a single input bit
    function automatic crc_t crc_bit(crc_t crc, logic bit_in);
        crc_t shifted;
        shifted = crc >> 1;
        if (crc[0] ^ bit_in) begin
            return shifted ^ CRC_POLY_REFLECTED;
        end
        return shifted;
    endfunction

    // loops unroll into a flat xor network
    always_comb begin
        crc_t crc;
        crc = crc_state;
        // byte 0 first, and bit 0 of each byte first
        for (int b = 0; b < data_bytes; b++) begin
            for (int i = 0; i < 8; i++) begin
                crc = crc_bit(crc, data_in[8*b+i]);
            end
        end
        crc_next = crc;
    end

endmodule

//--- xgmii_lane_align.sv
//////////////////////////////////////////////////////////////////////
// XGMII receive lane aligner
// moves a frame that starts in lane 4 so that it starts in lane 0
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ns

module xgmii_lane_align (
    input  logic                    clk,
    input  logic                    rst,
    input  eth_rx_pkg::xgmii_data_t xgmii_rxd,
    input  eth_rx_pkg::xgmii_ctrl_t xgmii_rxc,
    output eth_rx_pkg::xgmii_data_t aligned_rxd,
    output eth_rx_pkg::xgmii_ctrl_t aligned_rxc
);
    import eth_rx_pkg::*;

    // set while output words are joined from two input words
    logic swapped;

    // upper half of the previous input word
    logic [31:0] swap_rxd;
    logic [3:0]  swap_rxc;

    logic start_lane0;
    logic start_lane4;

    assign start_lane0 = xgmii_rxc[0] && (xgmii_rxd[7:0] == XGMII_START);
    assign start_lane4 = xgmii_rxc[4] && (xgmii_rxd[39:32] == XGMII_START);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            swapped     <= 1'b0;
            aligned_rxd <= XGMII_IDLE_WORD;
            aligned_rxc <= XGMII_IDLE_CTRL;
        end else if (start_lane0) begin
            // lane 0 start, back to straight pass
            swapped     <= 1'b0;
            aligned_rxd <= xgmii_rxd;
            aligned_rxc <= xgmii_rxc;
        end else if (swapped) begin
            // a lane 4 start here simply continues the join
            aligned_rxd <= {xgmii_rxd[31:0], swap_rxd};
            aligned_rxc <= {xgmii_rxc[3:0], swap_rxc};
        end else if (start_lane4) begin
            // keep the lower half, the start shows up next word
            swapped     <= 1'b1;
            aligned_rxd <= {{4{XGMII_IDLE}}, xgmii_rxd[31:0]};
            aligned_rxc <= {4'hF, xgmii_rxc[3:0]};
        end else begin
            aligned_rxd <= xgmii_rxd;
            aligned_rxc <= xgmii_rxc;
        end
    end

    always_ff @(posedge clk) begin
        swap_rxd <= xgmii_rxd[63:32];
        swap_rxc <= xgmii_rxc[7:4];
    end

endmodule

//--- eth_mac_rx_framer.sv
//////////////////////////////////////////////////////////////////////
// 10G receive framer
// strips the start word, checks the FCS and emits a keep/last stream
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ns

module eth_mac_rx_framer (
    input  logic                    clk,
    input  logic                    rst,
    input  eth_rx_pkg::xgmii_data_t aligned_rxd,
    input  eth_rx_pkg::xgmii_ctrl_t aligned_rxc,
    output eth_rx_pkg::xgmii_data_t axis_tdata,
    output eth_rx_pkg::xgmii_ctrl_t axis_tkeep,
    output logic                    axis_tvalid,
    output logic                    axis_tlast,
    output logic                    axis_tuser,
    output logic                    error_bad_frame,
    output logic                    error_bad_fcs,
    output logic                    frame_done
);
    import eth_rx_pkg::*;

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_PAYLOAD,
        ST_LAST
    } rx_state_t;

    rx_state_t state;
    rx_state_t state_next;

    // word on its way to the output, aligned_rxd is one word ahead
    xgmii_data_t rxd_d1;
    xgmii_ctrl_t rxc_d1;

    // crc_state covers the frame up to and including rxd_d1
    crc_t crc_state;
    crc_t crc_out [1:8];
    crc_t crc_save [4:7];
    logic update_crc;

    logic [7:0] det_start;
    logic [7:0] det_term;
    logic [7:0] det_err;
    logic [7:0] err_masked;
    logic [7:0] err_d1;
    logic       start_d1;
    logic       term_any;
    logic [2:0] term_lane;

    crc_t fcs_calc;
    crc_t fcs_rx;
    logic fcs_bad;

    // outcome held for the extra tail cycle
    xgmii_ctrl_t last_keep;
    xgmii_ctrl_t last_keep_next;
    logic        last_bad;
    logic        last_bad_next;

    xgmii_ctrl_t keep_next;
    logic        valid_next;
    logic        last_next;
    logic        user_next;
    logic        bad_frame_next;
    logic        bad_fcs_next;

    // one CRC step per possible number of bytes in the lookahead word
    for (genvar g = 1; g <= 8; g++) begin : g_crc
        eth_crc_update #(
            .data_bytes(g)
        ) crc_inst (
            .data_in  (aligned_rxd[8*g-1:0]),
            .crc_state(crc_state),
            .crc_next (crc_out[g])
        );
    end

    // control characters per lane
    always_comb begin
        for (int i = 0; i < 8; i++) begin
            det_start[i] = aligned_rxc[i] && (aligned_rxd[8*i +: 8] == XGMII_START);
            det_term[i]  = aligned_rxc[i] && (aligned_rxd[8*i +: 8] == XGMII_TERM);
            det_err[i]   = aligned_rxc[i] && (aligned_rxd[8*i +: 8] == XGMII_ERROR);
            err_d1[i]    = rxc_d1[i] && (rxd_d1[8*i +: 8] == XGMII_ERROR);
        end
    end

    assign start_d1 = rxc_d1[0] && (rxd_d1[7:0] == XGMII_START);

    // first terminate wins, errors behind it do not count
    always_comb begin
        term_any   = 1'b0;
        term_lane  = 3'd0;
        err_masked = '0;
        for (int i = 0; i < 8; i++) begin
            if (!term_any) begin
                err_masked[i] = det_err[i];
                if (det_term[i]) begin
                    term_any  = 1'b1;
                    term_lane = 3'(i);
                end
            end
        end
    end

    // received FCS and the remainder over the data before it
    always_comb begin
        case (term_lane)
            3'd0: begin
                fcs_calc = crc_save[4];
                fcs_rx   = rxd_d1[63:32];
            end
            3'd1: begin
                fcs_calc = crc_save[5];
                fcs_rx   = {aligned_rxd[7:0], rxd_d1[63:40]};
            end
            3'd2: begin
                fcs_calc = crc_save[6];
                fcs_rx   = {aligned_rxd[15:0], rxd_d1[63:48]};
            end
            3'd3: begin
                fcs_calc = crc_save[7];
                fcs_rx   = {aligned_rxd[23:0], rxd_d1[63:56]};
            end
            3'd4: begin
                fcs_calc = crc_state;
                fcs_rx   = aligned_rxd[31:0];
            end
            3'd5: begin
                fcs_calc = crc_out[1];
                fcs_rx   = aligned_rxd[39:8];
            end
            3'd6: begin
                fcs_calc = crc_out[2];
                fcs_rx   = aligned_rxd[47:16];
            end
            default: begin
                fcs_calc = crc_out[3];
                fcs_rx   = aligned_rxd[55:24];
            end
        endcase
        fcs_bad = (fcs_rx != ~fcs_calc);
    end

    always_comb begin
        state_next     = state;
        update_crc     = 1'b0;
        valid_next     = 1'b0;
        keep_next      = '0;
        last_next      = 1'b0;
        user_next      = 1'b0;
        bad_frame_next = 1'b0;
        bad_fcs_next   = 1'b0;
        last_keep_next = last_keep;
        last_bad_next  = last_bad;
        case (state)
            ST_IDLE: begin
                // start word itself is dropped
                if (start_d1) begin
                    update_crc = 1'b1;
                    state_next = ST_PAYLOAD;
                end
            end
            ST_PAYLOAD: begin
                valid_next = 1'b1;
                keep_next  = '1;
                if ((|det_start) || (|err_d1) || (|err_masked)) begin
                    // close the frame early and mark it bad
                    last_next      = 1'b1;
                    user_next      = 1'b1;
                    bad_frame_next = 1'b1;
                    state_next     = ST_IDLE;
                end else if (term_any && (term_lane == 3'd0)) begin
                    // FCS ends exactly in this word
                    last_next      = 1'b1;
                    user_next      = fcs_bad;
                    bad_frame_next = fcs_bad;
                    bad_fcs_next   = fcs_bad;
                    state_next     = ST_IDLE;
                end else if (term_any) begin
                    last_keep_next = ~(8'hFF << term_lane);
                    last_bad_next  = fcs_bad;
                    state_next     = ST_LAST;
                end else begin
                    update_crc = 1'b1;
                end
            end
            ST_LAST: begin
                // tail word with the rest of the FCS
                valid_next     = 1'b1;
                keep_next      = last_keep;
                last_next      = 1'b1;
                user_next      = last_bad;
                bad_frame_next = last_bad;
                bad_fcs_next   = last_bad;
                state_next     = ST_IDLE;
            end
            default: state_next = ST_IDLE;
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state           <= ST_IDLE;
            rxd_d1          <= XGMII_IDLE_WORD;
            rxc_d1          <= XGMII_IDLE_CTRL;
            crc_state       <= CRC_INIT;
            last_keep       <= '0;
            last_bad        <= 1'b0;
            axis_tkeep      <= '0;
            axis_tvalid     <= 1'b0;
            axis_tlast      <= 1'b0;
            axis_tuser      <= 1'b0;
            error_bad_frame <= 1'b0;
            error_bad_fcs   <= 1'b0;
        end else begin
            state           <= state_next;
            rxd_d1          <= aligned_rxd;
            rxc_d1          <= aligned_rxc;
            crc_state       <= update_crc ? crc_out[8] : CRC_INIT;
            last_keep       <= last_keep_next;
            last_bad        <= last_bad_next;
            axis_tkeep      <= keep_next;
            axis_tvalid     <= valid_next;
            axis_tlast      <= last_next;
            axis_tuser      <= user_next;
            error_bad_frame <= bad_frame_next;
            error_bad_fcs   <= bad_fcs_next;
        end
    end

    // partial remainders for a terminate in lanes 0 to 3 of the next word
    always_ff @(posedge clk) begin
        if (update_crc) begin
            crc_save[4] <= crc_out[4];
            crc_save[5] <= crc_out[5];
            crc_save[6] <= crc_out[6];
            crc_save[7] <= crc_out[7];
        end
        axis_tdata <= rxd_d1;
    end

    assign frame_done = axis_tlast;

endmodule

//--- eth_mac_rx_stats.sv
//////////////////////////////////////////////////////////////////////
// receive frame counters
// saturating counts of good frames, bad frames and FCS errors
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ns

module eth_mac_rx_stats (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     frame_done,
    input  logic                     error_bad_frame,
    input  logic                     error_bad_fcs,
    output eth_rx_pkg::frame_count_t count_good,
    output eth_rx_pkg::frame_count_t count_bad,
    output eth_rx_pkg::frame_count_t count_fcs
);
    import eth_rx_pkg::*;

    // stops at all ones instead of wrapping
    function automatic frame_count_t sat_inc(frame_count_t value);
        if (value == '1) begin
            return value;
        end
        return value + 1'b1;
    endfunction

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            count_good <= '0;
            count_bad  <= '0;
            count_fcs  <= '0;
        end else begin
            if (frame_done && !error_bad_frame) begin
                count_good <= sat_inc(count_good);
            end
            if (frame_done && error_bad_frame) begin
                count_bad <= sat_inc(count_bad);
            end
            // fcs errors are also counted as bad frames above
            if (error_bad_fcs) begin
                count_fcs <= sat_inc(count_fcs);
            end
        end
    end

endmodule

//--- eth_mac_10g_rx.sv
//////////////////////////////////////////////////////////////////////
// 10G Ethernet MAC receive path, top level
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ns

module eth_mac_10g_rx (
    input  logic                     clk,
    input  logic                     rst,
    input  eth_rx_pkg::xgmii_data_t  xgmii_rxd,
    input  eth_rx_pkg::xgmii_ctrl_t  xgmii_rxc,
    output eth_rx_pkg::xgmii_data_t  axis_tdata,
    output eth_rx_pkg::xgmii_ctrl_t  axis_tkeep,
    output logic                     axis_tvalid,
    output logic                     axis_tlast,
    output logic                     axis_tuser,
    output logic                     error_bad_frame,
    output logic                     error_bad_fcs,
    output eth_rx_pkg::frame_count_t count_good,
    output eth_rx_pkg::frame_count_t count_bad,
    output eth_rx_pkg::frame_count_t count_fcs
);
    import eth_rx_pkg::*;

    xgmii_data_t aligned_rxd;
    xgmii_ctrl_t aligned_rxc;
    logic        frame_done;

    xgmii_lane_align align_inst (
        .clk        (clk),
        .rst        (rst),
        .xgmii_rxd  (xgmii_rxd),
        .xgmii_rxc  (xgmii_rxc),
        .aligned_rxd(aligned_rxd),
        .aligned_rxc(aligned_rxc)
    );

    eth_mac_rx_framer framer_inst (
        .clk            (clk),
        .rst            (rst),
        .aligned_rxd    (aligned_rxd),
        .aligned_rxc    (aligned_rxc),
        .axis_tdata     (axis_tdata),
        .axis_tkeep     (axis_tkeep),
        .axis_tvalid    (axis_tvalid),
        .axis_tlast     (axis_tlast),
        .axis_tuser     (axis_tuser),
        .error_bad_frame(error_bad_frame),
        .error_bad_fcs  (error_bad_fcs),
        .frame_done     (frame_done)
    );

    eth_mac_rx_stats stats_inst (
        .clk            (clk),
        .rst            (rst),
        .frame_done     (frame_done),
        .error_bad_frame(error_bad_frame),
        .error_bad_fcs  (error_bad_fcs),
        .count_good     (count_good),
        .count_bad      (count_bad),
        .count_fcs      (count_fcs)
    );

endmodule

//--- eth_mac_rx_chk.sv
//////////////////////////////////////////////////////////////////////
// protocol checks on the receive MAC stream and status outputs
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ns

module eth_mac_rx_chk (
    input logic                    clk,
    input logic                    rst,
    input eth_rx_pkg::xgmii_ctrl_t axis_tkeep,
    input logic                    axis_tvalid,
    input logic                    axis_tlast,
    input logic                    axis_tuser,
    input logic                    error_bad_frame,
    input logic                    error_bad_fcs
);

    // number of failed checks
    int fail_count = 0;

    last_has_valid: assert property (@(posedge clk) disable iff (rst)
        axis_tlast |-> axis_tvalid)
        else begin
            fail_count++;
            $error("tlast seen without tvalid");
        end

    // an FCS error is always a bad frame
    fcs_is_bad_frame: assert property (@(posedge clk) disable iff (rst)
        error_bad_fcs |-> (error_bad_frame && axis_tuser))
        else begin
            fail_count++;
            $error("bad FCS without bad frame and tuser");
        end

    bad_frame_at_last: assert property (@(posedge clk) disable iff (rst)
        error_bad_frame |-> axis_tlast)
        else begin
            fail_count++;
            $error("bad frame pulse outside the last word");
        end

    full_keep_mid_frame: assert property (@(posedge clk) disable iff (rst)
        (axis_tvalid && !axis_tlast) |-> (axis_tkeep == 8'hFF))
        else begin
            fail_count++;
            $error("partial keep before the last word");
        end

    // keep+1 has no bit in common with keep when it is a run of ones from bit 0
    contiguous_keep: assert property (@(posedge clk) disable iff (rst)
        (axis_tvalid && axis_tlast) |->
            ((axis_tkeep != 8'h00) && ((axis_tkeep & (axis_tkeep + 8'd1)) == 8'h00)))
        else begin
            fail_count++;
            $error("keep on the last word is not contiguous from byte 0");
        end

    quiet_in_reset: assert property (@(posedge clk)
        rst |-> !(axis_tvalid || axis_tlast || axis_tuser || error_bad_frame || error_bad_fcs))
        else begin
            fail_count++;
            $error("outputs active during reset");
        end

endmodule

bind eth_mac_10g_rx eth_mac_rx_chk chk_inst (.*);

//--- tb_eth_mac_rx.sv
//////////////////////////////////////////////////////////////////////
// testbench for the 10G Ethernet receive MAC
// random frames with a reference CRC, byte scoreboard, counter checks
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ns

module tb_eth_mac_rx;
    import eth_rx_pkg::*;

    logic         clk;
    logic         rst;
    xgmii_data_t  xgmii_rxd;
    xgmii_ctrl_t  xgmii_rxc;
    xgmii_data_t  axis_tdata;
    xgmii_ctrl_t  axis_tkeep;
    logic         axis_tvalid;
    logic         axis_tlast;
    logic         axis_tuser;
    logic         error_bad_frame;
    logic         error_bad_fcs;
    frame_count_t count_good;
    frame_count_t count_bad;
    frame_count_t count_fcs;

    // bytes still to be driven, one control flag each
    logic [7:0] tx_byte [$];
    logic       tx_ctl [$];
    // payload plus FCS of the frame being built
    logic [7:0] body [$];
    // scoreboard entries
    logic [7:0] exp_byte [$];
    int         exp_len [$];
    logic       exp_user [$];
    logic       exp_fcs [$];

    int errors = 0;
    int frames_seen = 0;
    int rx_bytes = 0;

    eth_mac_10g_rx uut (.*);

    always #50 clk = ~clk;

    task automatic report_mismatch(string msg);
        errors++;
        $display("FAIL %0t ns: %s", $time, msg);
    endtask

    // serial CRC-32, bit 0 of each byte first
    function automatic crc_t crc_ref_byte(crc_t crc, logic [7:0] d);
        for (int i = 0; i < 8; i++) begin
            crc = (crc[0] ^ d[i]) ? ((crc >> 1) ^ CRC_POLY_REFLECTED) : (crc >> 1);
        end
        return crc;
    endfunction

    task automatic put(logic [7:0] b, logic ctl);
        tx_byte.push_back(b);
        tx_ctl.push_back(ctl);
    endtask

    // random payload, then the inverted remainder low byte first
    task automatic make_body(int len);
        crc_t       crc;
        logic [7:0] b;
        crc = CRC_INIT;
        body.delete();
        for (int i = 0; i < len; i++) begin
            b = 8'($urandom);
            body.push_back(b);
            crc = crc_ref_byte(crc, b);
        end
        crc = ~crc;
        for (int i = 0; i < 4; i++) begin
            body.push_back(crc[8*i +: 8]);
        end
    endtask

    task automatic expect_frame(int n, logic user, logic fcs);
        for (int i = 0; i < n; i++) begin
            exp_byte.push_back(body[i]);
        end
        exp_len.push_back(n);
        exp_user.push_back(user);
        exp_fcs.push_back(fcs);
    endtask

    // start word, then nbytes of body; body byte err_pos becomes an error char
    task automatic push_frame(logic lane4, int nbytes, int err_pos);
        if (lane4) begin
            repeat (4) put(XGMII_IDLE, 1'b1);
        end
        put(XGMII_START, 1'b1);
        repeat (6) put(8'h55, 1'b0);
        put(8'hD5, 1'b0);
        for (int i = 0; i < nbytes; i++) begin
            if (i == err_pos) begin
                put(XGMII_ERROR, 1'b1);
            end else begin
                put(body[i], 1'b0);
            end
        end
    endtask

    // pad to a word, add two idle words, then drive one word per clock
    task automatic drive_stream();
        xgmii_data_t d;
        xgmii_ctrl_t c;
        while (tx_byte.size() % 8 != 0) begin
            put(XGMII_IDLE, 1'b1);
        end
        repeat (16) put(XGMII_IDLE, 1'b1);
        while (tx_byte.size() > 0) begin
            for (int i = 0; i < 8; i++) begin
                d[8*i +: 8] = tx_byte.pop_front();
                c[i] = tx_ctl.pop_front();
            end
            @(posedge clk);
            xgmii_rxd <= d;
            xgmii_rxc <= c;
        end
    endtask

    task automatic send_good_frame(int len, logic lane4);
        make_body(len);
        expect_frame(len + 4, 1'b0, 1'b0);
        push_frame(lane4, len + 4, -1);
        put(XGMII_TERM, 1'b1);
        drive_stream();
    endtask

    task automatic wait_frames(int n);
        int waited;
        waited = 0;
        while (frames_seen < n && waited < 200) begin
            @(posedge clk);
            waited++;
        end
        if (frames_seen < n) begin
            $display("timeout: only %0d of %0d frames left the DUT", frames_seen, n);
            $display(">>> FAIL");
            $finish;
        end
    endtask

    // counters move one edge after the tlast word
    task automatic check_counts(int good, int bad, int fcs);
        @(negedge clk);
        assert (count_good == frame_count_t'(good))
            else report_mismatch($sformatf("count_good %0d, expected %0d", count_good, good));
        assert (count_bad == frame_count_t'(bad))
            else report_mismatch($sformatf("count_bad %0d, expected %0d", count_bad, bad));
        assert (count_fcs == frame_count_t'(fcs))
            else report_mismatch($sformatf("count_fcs %0d, expected %0d", count_fcs, fcs));
    endtask

    always @(negedge clk) begin : monitor
        logic [7:0] got;
        logic [7:0] want;
        int         want_len;
        logic       want_user;
        logic       want_fcs;
        if (!rst && axis_tvalid) begin
            for (int i = 0; i < 8; i++) begin
                if (axis_tkeep[i]) begin
                    got = axis_tdata[8*i +: 8];
                    if (exp_byte.size() == 0) begin
                        report_mismatch($sformatf("unexpected byte %02h", got));
                    end else begin
                        want = exp_byte.pop_front();
                        assert (got == want)
                            else report_mismatch($sformatf("byte %0d is %02h, expected %02h",
                                                           rx_bytes, got, want));
                    end
                    rx_bytes++;
                end
            end
            if (axis_tlast) begin
                if (exp_len.size() == 0) begin
                    report_mismatch("frame ended with no frame expected");
                end else begin
                    want_len = exp_len.pop_front();
                    want_user = exp_user.pop_front();
                    want_fcs = exp_fcs.pop_front();
                    assert (rx_bytes == want_len)
                        else report_mismatch($sformatf("frame %0d has %0d bytes, expected %0d",
                                                       frames_seen, rx_bytes, want_len));
                    assert (axis_tuser == want_user && error_bad_frame == want_user)
                        else report_mismatch($sformatf("frame %0d tuser %0b bad_frame %0b",
                                                       frames_seen, axis_tuser, error_bad_frame));
                    assert (error_bad_fcs == want_fcs)
                        else report_mismatch($sformatf("frame %0d bad_fcs %0b, expected %0b",
                                                       frames_seen, error_bad_fcs, want_fcs));
                end
                frames_seen++;
                rx_bytes = 0;
            end
        end
    end

    initial begin
        void'($urandom(38568));
        clk = 1'b0;
        rst = 1'b1;
        xgmii_rxd = XGMII_IDLE_WORD;
        xgmii_rxc = XGMII_IDLE_CTRL;
        repeat (4) @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);
        assert (!(axis_tvalid || axis_tlast || axis_tuser || error_bad_frame || error_bad_fcs))
            else report_mismatch("outputs not quiet after reset");
        check_counts(0, 0, 0);

        // lengths step through all eight tail positions
        for (int k = 0; k < 8; k++) begin
            send_good_frame(60 + k + 8 * int'($urandom_range(0, 3)), 1'b0);
        end
        wait_frames(8);
        check_counts(8, 0, 0);

        // one flipped FCS bit
        make_body(61);
        body[64] = body[64] ^ 8'h10;
        expect_frame(65, 1'b1, 1'b1);
        push_frame(1'b0, 65, -1);
        put(XGMII_TERM, 1'b1);
        drive_stream();
        wait_frames(9);
        check_counts(8, 1, 1);

        // error char in the third body word cuts the frame after two words
        make_body(80);
        expect_frame(16, 1'b1, 1'b0);
        push_frame(1'b0, 84, 20);
        put(XGMII_TERM, 1'b1);
        drive_stream();
        // error char right behind the terminate
        make_body(61);
        expect_frame(65, 1'b0, 1'b0);
        push_frame(1'b0, 65, -1);
        put(XGMII_TERM, 1'b1);
        put(XGMII_ERROR, 1'b1);
        drive_stream();
        wait_frames(11);
        check_counts(9, 2, 1);

        // same frame from lane 0 and from lane 4
        make_body(70);
        expect_frame(74, 1'b0, 1'b0);
        expect_frame(74, 1'b0, 1'b0);
        push_frame(1'b0, 74, -1);
        put(XGMII_TERM, 1'b1);
        drive_stream();
        push_frame(1'b1, 74, -1);
        put(XGMII_TERM, 1'b1);
        drive_stream();
        wait_frames(13);
        check_counts(11, 2, 1);

        // a new start after two body words closes the first frame
        make_body(40);
        expect_frame(16, 1'b1, 1'b0);
        push_frame(1'b0, 16, -1);
        make_body(50);
        expect_frame(54, 1'b0, 1'b0);
        push_frame(1'b0, 54, -1);
        put(XGMII_TERM, 1'b1);
        drive_stream();
        wait_frames(15);
        check_counts(12, 3, 1);

        assert (exp_byte.size() == 0)
            else report_mismatch($sformatf("%0d expected bytes never arrived", exp_byte.size()));
        $display("errors: %0d scoreboard, %0d protocol", errors, uut.chk_inst.fail_count);
        if (errors == 0 && uut.chk_inst.fail_count == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

//--- sim.f
eth_rx_pkg.sv
eth_crc_update.sv
xgmii_lane_align.sv
eth_mac_rx_framer.sv
eth_mac_rx_stats.sv
eth_mac_10g_rx.sv
eth_mac_rx_chk.sv
tb_eth_mac_rx.sv

//--- Makefile
# Verilator build and run for the 10G Ethernet receive MAC

VERILATOR ?= verilator
TOP       ?= tb_eth_mac_rx
FILELIST  ?= sim.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert
PASS_TEXT ?= >>> PASS

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"
	@echo "variables: VERILATOR TOP FILELIST BUILD_DIR VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q -x -F -- "$(PASS_TEXT)"

clean:
	rm -rf $(BUILD_DIR)
